//--- verilog/imuldiv_settings.svh
// width and step count settings for the iterative multiply/divide unit
// shared by the RTL and the testbench

`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// operand width in bits
`define IMULDIV_XLEN 32

// one step per operand bit
`define IMULDIV_STEPS 32

// step counter width
// must hold the value IMULDIV_STEPS
`define IMULDIV_CNT_W 6

`endif

//--- verilog/imuldiv_op_pkg.sv
// function codes of the multiply/divide unit
// and helpers that classify them

package imuldiv_op_pkg;

  // request function code
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } imuldiv_fn_e;

  // true when operands are taken as two's complement
  function automatic logic fn_is_signed(imuldiv_fn_e fn);
    return (fn == fn_mul) || (fn == fn_div);
  endfunction

  // true for both divide functions
  function automatic logic fn_is_div(imuldiv_fn_e fn);
    return (fn == fn_div) || (fn == fn_divu);
  endfunction

endpackage

//--- verilog/imuldiv_fsm_pkg.sv
// control FSM state type of the multiply/divide unit

package imuldiv_fsm_pkg;

  // idle waits for a request
  // calc runs the step cycles
  // done holds the response until it is taken
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } imuldiv_state_e;

endpackage

//--- verilog/imuldiv_step_if.sv
// step command bus from the control FSM to both datapaths

`timescale 1ns/1ps

interface imuldiv_step_if
  import imuldiv_op_pkg::*;
();

  // one cycle on request accept
  // datapaths capture operands and signs on it
  logic load;

  // one iteration of add-shift or shift-subtract
  logic step;

  // function of the request in flight
  imuldiv_fn_e fn;

  // high for the whole calc phase
  logic busy;

  modport ctrl (output load, output step, output fn, output busy);

  modport dpath (input load, input step, input fn, input busy);

endinterface

//--- verilog/imuldiv_ctrl.sv
// control FSM of the multiply/divide unit
// valid/ready handshake, step counter and function code latch

`timescale 1ns/1ps

`include "imuldiv_settings.svh"

module imuldiv_ctrl
  import imuldiv_op_pkg::*, imuldiv_fsm_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  imuldiv_fn_e  req_fn,
  input  logic         req_val,
  output logic         req_rdy,
  output logic         resp_val,
  input  logic         resp_rdy,
  imuldiv_step_if.ctrl step
);

  // counter value during the final step cycle
  localparam int unsigned last_step = `IMULDIV_STEPS - 1;

  imuldiv_state_e            state;
  logic [`IMULDIV_CNT_W-1:0] count;
  imuldiv_fn_e               fn_reg;
  logic                      req_go;
  logic                      resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------------------------------
  // state and counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      count  <= '0;
      fn_reg <= fn_mul;
    end else begin
      case (state)
        st_idle: begin
          // accept edge also loads the datapaths
          if (req_go) begin
            state  <= st_calc;
            count  <= '0;
            fn_reg <= req_fn;
          end
        end
        st_calc: begin
          // leave on the edge that ends the last step
          if (count == last_step[`IMULDIV_CNT_W-1:0]) begin
            state <= st_done;
          end
          count <= count + 1'b1;
        end
        st_done: begin
          // result held until the consumer takes it
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign step.load = req_go;
  assign step.step = (state == st_calc);
  assign step.busy = (state == st_calc);
  // datapaths see the incoming code in the load cycle, the latched one after
  assign step.fn   = req_go ? req_fn : fn_reg;

  // handshake sides never open together
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(step.load && step.step));

  // response is never dropped before the transfer
  a_done_hold: assert property (@(posedge clk) disable iff (reset)
    (state == st_done && !resp_go) |=> (state == st_done));

endmodule

//--- verilog/imuldiv_mul_dpath.sv
// add-shift multiplier datapath
// magnitude load, accumulate steps and final product negation

`timescale 1ns/1ps

`include "imuldiv_settings.svh"

module imuldiv_mul_dpath
  import imuldiv_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   a,
  input  logic [`IMULDIV_XLEN-1:0]   b,
  imuldiv_step_if.dpath              step,
  output logic [2*`IMULDIV_XLEN-1:0] result
);

  localparam int unsigned xlen = `IMULDIV_XLEN;

  logic              is_signed;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic [2*xlen-1:0] mcand;
  logic [xlen-1:0]   mplier;
  logic [2*xlen-1:0] acc;
  logic              neg;
  logic              loaded;

  // magnitudes only for the signed multiply
  assign is_signed = fn_is_signed(step.fn);
  assign a_mag     = (is_signed && a[xlen-1]) ? -a : a;
  assign b_mag     = (is_signed && b[xlen-1]) ? -b : b;

  // --------------------------------------------------------------------------
  // add-shift iteration
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (step.load) begin
      mcand  <= {{xlen{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      // product negative when exactly one operand is
      neg    <= is_signed && (a[xlen-1] ^ b[xlen-1]);
    end else if (step.step) begin
      // low multiplier bit selects this partial product
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // tracks whether the registers hold a loaded operation
  always_ff @(posedge clk) begin
    if (reset) begin
      loaded <= 1'b0;
    end else if (step.load) begin
      loaded <= 1'b1;
    end
  end

  assign result = neg ? -acc : acc;

  a_step_after_load: assert property (@(posedge clk) disable iff (reset)
    step.step |-> loaded);

endmodule

//--- verilog/imuldiv_div_dpath.sv
// restoring divider datapath
// magnitude load, shift-subtract steps and sign fix of quotient and remainder

`timescale 1ns/1ps

`include "imuldiv_settings.svh"

module imuldiv_div_dpath
  import imuldiv_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   a,
  input  logic [`IMULDIV_XLEN-1:0]   b,
  imuldiv_step_if.dpath              step,
  output logic [2*`IMULDIV_XLEN-1:0] result
);

  localparam int unsigned xlen = `IMULDIV_XLEN;

  logic            is_signed;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  // dividend bits leave at the top while quotient bits enter at the bottom
  logic [xlen-1:0] quo;
  logic [xlen-1:0] rem;
  logic [xlen-1:0] divisor;
  logic            q_neg;
  logic            r_neg;
  logic [xlen:0]   trial;
  logic [xlen:0]   diff;
  logic            fits;
  logic [xlen-1:0] quo_fix;
  logic [xlen-1:0] rem_fix;

  assign is_signed = fn_is_signed(step.fn);
  assign a_mag     = (is_signed && a[xlen-1]) ? -a : a;
  assign b_mag     = (is_signed && b[xlen-1]) ? -b : b;

  // --------------------------------------------------------------------------
  // shift-subtract iteration
  // --------------------------------------------------------------------------

  // partial remainder with the next dividend bit shifted in
  assign trial = {rem, quo[xlen-1]};
  assign diff  = trial - {1'b0, divisor};
  assign fits  = (trial >= {1'b0, divisor});

  always_ff @(posedge clk) begin
    if (step.load) begin
      quo     <= a_mag;
      rem     <= '0;
      divisor <= b_mag;
      q_neg   <= is_signed && (a[xlen-1] ^ b[xlen-1]);
      // remainder follows the dividend sign
      r_neg   <= is_signed && a[xlen-1];
    end else if (step.step) begin
      quo <= {quo[xlen-2:0], fits};
      // restore by keeping the unsubtracted value
      if (fits) begin
        rem <= diff[xlen-1:0];
      end else begin
        rem <= trial[xlen-1:0];
      end
    end
  end

  // most negative over -1 wraps back to itself here
  assign quo_fix = q_neg ? -quo : quo;
  assign rem_fix = r_neg ? -rem : rem;
  assign result  = {rem_fix, quo_fix};

  // a zero divisor has no defined result
  a_divisor_nonzero: assert property (@(posedge clk) disable iff (reset)
    (step.busy && fn_is_div(step.fn)) |-> (divisor != '0));

endmodule

//--- verilog/imuldiv_iterative.sv
// iterative multiply/divide unit top level
// control FSM, both datapaths and the response select

`timescale 1ns/1ps

`include "imuldiv_settings.svh"

module imuldiv_iterative
  import imuldiv_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_XLEN-1:0]   req_a,
  input  logic [`IMULDIV_XLEN-1:0]   req_b,
  input  imuldiv_fn_e                req_fn,
  input  logic                       req_val,
  output logic                       req_rdy,
  output logic [2*`IMULDIV_XLEN-1:0] resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic [2*`IMULDIV_XLEN-1:0] mul_result;
  logic [2*`IMULDIV_XLEN-1:0] div_result;

  // load/step commands shared by both datapaths
  imuldiv_step_if step_bus ();

  imuldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_fn   (req_fn),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .step     (step_bus)
  );

  imuldiv_mul_dpath u_mul (
    .clk    (clk),
    .reset  (reset),
    .a      (req_a),
    .b      (req_b),
    .step   (step_bus),
    .result (mul_result)
  );

  imuldiv_div_dpath u_div (
    .clk    (clk),
    .reset  (reset),
    .a      (req_a),
    .b      (req_b),
    .step   (step_bus),
    .result (div_result)
  );

  // latched code stays fixed through done so the response holds
  assign resp_result = fn_is_div(step_bus.fn) ? div_result : mul_result;

endmodule

//--- testbench/tb_imuldiv.sv
// testbench for the iterative multiply/divide unit
// xorshift stimulus, reference model, concurrent checks and report

`timescale 1ns/1ps

`include "imuldiv_settings.svh"

module tb_imuldiv
  import imuldiv_op_pkg::*;
();

  localparam int xlen       = `IMULDIV_XLEN;
  localparam int wait_limit = 200;

  logic                clk;
  logic                reset;
  logic [xlen-1:0]     req_a;
  logic [xlen-1:0]     req_b;
  imuldiv_fn_e         req_fn;
  logic                req_val;
  logic                req_rdy;
  logic [2*xlen-1:0]   resp_result;
  logic                resp_val;
  logic                resp_rdy;

  logic [2*xlen-1:0]   exp_q[$];
  logic [2*xlen-1:0]   expected;
  logic                in_flight;
  int                  since_accept;
  logic [31:0]         rng;
  string               test_name;
  int                  errors;
  int                  test_errors;
  int                  tests_run;
  int                  tests_failed;

  imuldiv_iterative DUT (
    .clk(clk), .reset(reset), .req_a(req_a), .req_b(req_b), .req_fn(req_fn),
    .req_val(req_val), .req_rdy(req_rdy), .resp_result(resp_result),
    .resp_val(resp_val), .resp_rdy(resp_rdy)
  );

  always #20 clk = ~clk;

  // ------------------------------------------------------------------------
  // reference model and scoreboard
  // ------------------------------------------------------------------------

  function automatic logic [2*xlen-1:0] model(input imuldiv_fn_e fn,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic signed [2*xlen-1:0] sa;
    logic signed [2*xlen-1:0] sb;
    logic signed [2*xlen-1:0] q;
    logic signed [2*xlen-1:0] r;
    sa = {{xlen{a[xlen-1]}}, a};
    sb = {{xlen{b[xlen-1]}}, b};
    case (fn)
      fn_mul:  return sa * sb;
      fn_mulu: return {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
      fn_div: begin
        // truncating division with the remainder keeping the dividend sign
        q = sa / sb;
        r = sa % sb;
        return {r[xlen-1:0], q[xlen-1:0]};
      end
      default: return {a % b, a / b};
    endcase
  endfunction

  // one request in flight at most, so the head is the next response
  always @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
      since_accept <= 0;
      exp_q.delete();
    end else begin
      since_accept <= since_accept + 1;
      if (req_val && req_rdy) begin
        in_flight <= 1'b1;
        since_accept <= 1;
        exp_q.push_back(model(req_fn, req_a, req_b));
      end
      if (resp_val && resp_rdy) begin
        in_flight <= 1'b0;
        if (exp_q.size() > 0) void'(exp_q.pop_front());
      end
      if (exp_q.size() > 0) expected <= exp_q[0];
    end
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------

  a_reset_state: assert property (@(posedge clk) $fell(reset) |-> (req_rdy && !resp_val))
    else begin
      errors++;
      $display("%s: unit not idle after reset", test_name);
    end

  a_result: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy && in_flight) |-> (resp_result == expected))
    else begin
      errors++;
      $display("mismatch %s expected %h actual %h", test_name, $sampled(expected),
               $sampled(resp_result));
    end

  a_resp_owned: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> in_flight)
    else begin
      errors++;
      $display("%s: response without a request", test_name);
    end

  // first cycle of resp_val is 33 edges after the accepting edge
  a_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> (since_accept == 33))
    else begin
      errors++;
      $display("%s: latency was %0d edges", test_name, $sampled(since_accept));
    end

  a_no_accept: assert property (@(posedge clk) disable iff (reset) in_flight |-> !req_rdy)
    else begin
      errors++;
      $display("%s: request accepted while busy", test_name);
    end

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      errors++;
      $display("%s: response changed under back-pressure", test_name);
    end

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("%s: no %s within %0d cycles", test_name, what, wait_limit);
    $display("test failed");
    $finish;
  endtask

  // called and returning 2 ns after a rising edge
  task automatic run_op(input imuldiv_fn_e fn, input logic [xlen-1:0] a,
                        input logic [xlen-1:0] b, input int hold, input bit keep_val);
    int n;
    req_a = a;
    req_b = b;
    req_fn = fn;
    req_val = 1'b1;
    // a consumer without back-pressure is ready before the request goes in
    resp_rdy = (hold == 0);
    n = 0;
    while (!req_rdy && n < wait_limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!req_rdy) abort_on_timeout("request accept");
    @(posedge clk);
    #2;
    // keep_val leaves req_val high through calc and done
    if (!keep_val) req_val = 1'b0;
    n = 0;
    while (!resp_val && n < wait_limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!resp_val) abort_on_timeout("response");
    repeat (hold) begin
      @(posedge clk);
      #2;
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
    req_val = 1'b0;
  endtask

  task automatic random_op(input imuldiv_fn_e fn, input int hold, input bit keep_val);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    rng = xorshift(rng);
    a = rng;
    rng = xorshift(rng);
    b = rng;
    // divisor never zero
    if (b == '0) b = 1;
    run_op(fn, a, b, hold, keep_val);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_errors) tests_failed++;
    $display("%s finished with %0d errors", test_name, errors - test_errors);
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    req_a = '0;
    req_b = '0;
    req_fn = fn_mul;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    rng = 32'h367b;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "reset_state";
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;

    begin_test("reset_state");
    run_op(fn_mul, 32'd3, 32'd5, 0, 0);
    run_op(fn_mulu, 32'd7, 32'd9, 0, 0);
    run_op(fn_mul, 32'd0, 32'h1234_5678, 0, 0);
    run_op(fn_mulu, 32'hffff_ffff, 32'hffff_ffff, 0, 0);
    run_op(fn_mul, 32'hffff_ffff, 32'hffff_ffff, 0, 0);
    end_test();

    begin_test("signed_mul");
    repeat (8) random_op(fn_mul, 0, 0);
    run_op(fn_mul, 32'h8000_0000, 32'hffff_ffff, 0, 0);
    run_op(fn_mul, 32'h8000_0000, 32'h8000_0000, 0, 0);
    end_test();

    begin_test("divide");
    repeat (4) random_op(fn_div, 0, 0);
    repeat (4) random_op(fn_divu, 0, 0);
    run_op(fn_div, -32'sd7, 32'd2, 0, 0);
    run_op(fn_div, 32'h8000_0000, 32'hffff_ffff, 0, 0);
    run_op(fn_divu, 32'd100, 32'd7, 0, 0);
    end_test();

    begin_test("latency");
    repeat (4) random_op(imuldiv_fn_e'(xorshift(rng) % 4), 0, 1);
    end_test();

    begin_test("back_pressure");
    repeat (6) begin
      rng = xorshift(rng);
      random_op(imuldiv_fn_e'(rng[1:0]), rng[15:8] % 11, 1);
    end
    end_test();

    $display("%0d tests, %0d failing, %0d failed checks", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/imuldiv_op_pkg.sv
verilog/imuldiv_fsm_pkg.sv
verilog/imuldiv_step_if.sv
verilog/imuldiv_ctrl.sv
verilog/imuldiv_mul_dpath.sv
verilog/imuldiv_div_dpath.sv
verilog/imuldiv_iterative.sv
testbench/tb_imuldiv.sv
